/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
src/mem_pkg.sv
src/clint.sv
src/data_ram.sv
src/lsu_stage.sv
src/mem_stage_top.sv
sim/mem_stage_sva.sv
sim/tb_mem_stage.sv

/* sim/mem_stage_sva.sv */
`timescale 1ns/1ps

module mem_stage_sva (
    input logic             clk,
    input logic             i_arst_n,
    input logic             o_ram_req,
    input logic             i_ram_rvalid,
    input logic             o_wb_valid,
    input logic             i_wb_allowin,
    input mem_pkg::wb_pkt_s o_wb_pkt
);
    logic pending_q;

    // open from the request until the read-valid pulse
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pending_q <= 1'b0;
        end else if (o_ram_req) begin
            pending_q <= 1'b1;
        end else if (i_ram_rvalid) begin
            pending_q <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!i_arst_n) o_ram_req |-> !pending_q)
        else $error("ram request raised again before read-valid");

    assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_wb_valid && !i_wb_allowin) |=> (o_wb_valid && $stable(o_wb_pkt)))
        else $error("writeback packet changed while stalled");

    assert property (@(posedge clk) !i_arst_n |-> !o_wb_valid)
        else $error("o_wb_valid high during reset");

endmodule

bind lsu_stage mem_stage_sva i_mem_stage_sva (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .o_ram_req    (o_ram_req),
    .i_ram_rvalid (i_ram_rvalid),
    .o_wb_valid   (o_wb_valid),
    .i_wb_allowin (i_wb_allowin),
    .o_wb_pkt     (o_wb_pkt)
);

/* sim/tb_mem_stage.sv */
`timescale 1ns/1ps

module tb_mem_stage;
    import mem_pkg::*;

    localparam int        CLK_PERIOD = 100;
    localparam bit [31:0] SEED       = 32'h2327_6b40;
    localparam int        FILL_WORDS = 16;
    localparam int        PASS_ITEMS = 8;
    localparam int        SL_ROUNDS  = 4;
    localparam int        BP_ITEMS   = 24;
    localparam int        MTIP_CMP   = 40;
    localparam mem_op_t   OP_LD      = 3'b111;

    // one item needs at most ITEM_CYCLES without stalls
    localparam int ITEM_CYCLES     = RAM_LATENCY + 4;
    localparam int RUN_ITEMS       = PASS_ITEMS + FILL_WORDS + 14 * SL_ROUNDS + 3 * BP_ITEMS + 16;
    localparam int RUN_CYCLES      = RUN_ITEMS * ITEM_CYCLES + 2 * MTIP_CMP + 20;
    localparam int WATCHDOG_CYCLES = 4 * RUN_CYCLES;

    logic    clk;
    logic    i_arst_n;
    logic    i_ex_valid;
    ex_pkt_s i_ex_pkt;
    logic    o_ex_ready;
    logic    o_wb_valid;
    wb_pkt_s o_wb_pkt;
    logic    i_wb_allowin;
    logic    o_mtip;

    int err_cnt;
    int checks;
    int tests_run;

    // byte image of the ram window
    logic [7:0] ref_mem [RAM_WORDS*8];

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    mem_stage_top i_mem_stage_top (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_ex_valid   (i_ex_valid),
        .i_ex_pkt     (i_ex_pkt),
        .o_ex_ready   (o_ex_ready),
        .o_wb_valid   (o_wb_valid),
        .o_wb_pkt     (o_wb_pkt),
        .i_wb_allowin (i_wb_allowin),
        .o_mtip       (o_mtip)
    );

    function automatic xlen_t dword_random();
        return {$urandom, $urandom};
    endfunction

    function automatic ex_pkt_s random_pkt();
        ex_pkt_s p;
        p.mem_wr  = 1'b0;
        p.mem_op  = MEM_OP_NONE;
        p.alu_res = dword_random();
        p.rs2     = dword_random();
        p.rs1     = dword_random();
        p.reg_src = reg_src_t'($urandom % 3);
        p.reg_wr  = 1'($urandom);
        p.intr_en = 1'($urandom);
        p.inst    = $urandom;
        p.pc      = dword_random();
        return p;
    endfunction

    function automatic ex_pkt_s mem_pkt(input logic wr, input mem_op_t op, input xlen_t addr,
                                        input xlen_t data);
        ex_pkt_s p;
        p         = random_pkt();
        p.mem_wr  = wr;
        p.mem_op  = op;
        p.alu_res = addr;
        p.rs2     = data;
        return p;
    endfunction

    // k of 0..5 walks size and sign and 6 gives the signed doubleword
    function automatic mem_op_t op_of(input int k);
        if (k >= 6) begin
            return OP_LD;
        end
        return mem_op_t'({k[0], k[2:1]});
    endfunction

    // naturally aligned address inside the filled part of the ram
    function automatic xlen_t ram_addr_for(input mem_op_t op);
        int nb;
        int off;
        nb  = 1 << op[1:0];
        off = ($urandom % FILL_WORDS) * 8 + (($urandom % 8) / nb) * nb;
        return RAM_BASE + xlen_t'(off);
    endfunction

    function automatic void write_ref_mem(input xlen_t addr, input mem_op_t op, input xlen_t data);
        int off;
        off = int'(addr - RAM_BASE);
        for (int i = 0; i < (1 << op[1:0]); i++) begin
            ref_mem[off + i] = data[8*i +: 8];
        end
    endfunction

    function automatic xlen_t predict_load(input xlen_t addr, input mem_op_t op);
        int    off;
        int    nb;
        xlen_t v;
        off = int'(addr - RAM_BASE);
        nb  = 1 << op[1:0];
        v   = '0;
        for (int i = 0; i < nb; i++) begin
            v[8*i +: 8] = ref_mem[off + i];
        end
        // signed loads copy the top loaded bit upward
        for (int i = 8 * nb; i < XLEN; i++) begin
            v[i] = op[2] & v[8*nb - 1];
        end
        return v;
    endfunction

    task automatic expect_eq(input string what, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pkt(input ex_pkt_s p, input bit chk_mem, input xlen_t exp_mem);
        expect_eq("alu_res", o_wb_pkt.alu_res, p.alu_res);
        expect_eq("reg_src", o_wb_pkt.reg_src, p.reg_src);
        expect_eq("reg_wr", o_wb_pkt.reg_wr, p.reg_wr);
        expect_eq("intr_en", o_wb_pkt.intr_en, p.intr_en);
        expect_eq("rs1", o_wb_pkt.rs1, p.rs1);
        expect_eq("inst", o_wb_pkt.inst, p.inst);
        expect_eq("pc", o_wb_pkt.pc, p.pc);
        if (chk_mem) begin
            expect_eq("mem_out", o_wb_pkt.mem_out, exp_mem);
        end
    endtask

    task automatic report_test(input string name, input int e0);
        tests_run++;
        if (err_cnt == e0) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, err_cnt - e0);
        end
    endtask

    // one item through the stage with allow-in high up to the cycle it is valid
    task automatic run_item(input ex_pkt_s p, input bit chk_mem, input xlen_t exp_mem,
                            input int exp_edges);
        int edges;
        @(posedge clk);
        i_ex_valid <= 1'b1;
        i_ex_pkt   <= p;
        @(negedge clk);
        while (!o_ex_ready) begin
            @(negedge clk);
        end
        // acceptance edge
        @(posedge clk);
        i_ex_valid <= 1'b0;
        edges = 0;
        @(negedge clk);
        while (!o_wb_valid) begin
            edges++;
            @(negedge clk);
        end
        expect_eq("edges from acceptance to o_wb_valid", edges, exp_edges);
        check_pkt(p, chk_mem, exp_mem);
    endtask

    task automatic pass_through();
        int e0;
        e0 = err_cnt;
        for (int i = 0; i < PASS_ITEMS; i++) begin
            run_item(random_pkt(), 1'b0, '0, 0);
        end
        report_test("pass_through", e0);
    endtask

    task automatic store_then_load();
        int      e0;
        mem_op_t op;
        xlen_t   a;
        xlen_t   d;
        e0 = err_cnt;
        for (int w = 0; w < FILL_WORDS; w++) begin
            a = RAM_BASE + xlen_t'(w * 8);
            d = dword_random();
            write_ref_mem(a, OP_LD, d);
            run_item(mem_pkt(1'b1, OP_LD, a, d), 1'b0, '0, RAM_LATENCY + 1);
        end
        for (int k = 0; k < 7; k++) begin
            op = op_of(k);
            for (int r = 0; r < SL_ROUNDS; r++) begin
                a = ram_addr_for(op);
                d = dword_random();
                write_ref_mem(a, op, d);
                run_item(mem_pkt(1'b1, op, a, d), 1'b0, '0, RAM_LATENCY + 1);
                run_item(mem_pkt(1'b0, op, a, dword_random()), 1'b1, predict_load(a, op),
                         RAM_LATENCY + 1);
            end
        end
        report_test("store_then_load", e0);
    endtask

    task automatic back_pressure();
        ex_pkt_s q[$];
        xlen_t   ev[$];
        bit      ec[$];
        ex_pkt_s p;
        mem_op_t op;
        xlen_t   a;
        int      sel;
        int      got;
        int      e0;
        e0 = err_cnt;
        // mix of pass-through items, ram loads and mtimecmp loads
        for (int i = 0; i < BP_ITEMS; i++) begin
            sel = $urandom % 3;
            if (sel == 0) begin
                p = random_pkt();
                ev.push_back('0);
                ec.push_back(1'b0);
            end else if (sel == 1) begin
                op = op_of($urandom % 7);
                a  = ram_addr_for(op);
                p  = mem_pkt(1'b0, op, a, dword_random());
                ev.push_back(predict_load(a, op));
                ec.push_back(1'b1);
            end else begin
                p = mem_pkt(1'b0, OP_LD, CLINT_MTIMECMP_ADDR, dword_random());
                ev.push_back('1);
                ec.push_back(1'b1);
            end
            q.push_back(p);
        end
        fork
            begin
                @(posedge clk);
                i_ex_valid <= 1'b1;
                i_ex_pkt   <= q[0];
                for (int k = 0; k < BP_ITEMS; k++) begin
                    @(negedge clk);
                    while (!o_ex_ready) begin
                        @(negedge clk);
                    end
                    @(posedge clk);
                    if (k + 1 < BP_ITEMS) begin
                        i_ex_pkt <= q[k+1];
                    end else begin
                        i_ex_valid <= 1'b0;
                    end
                end
            end
            begin
                got = 0;
                while (got < BP_ITEMS) begin
                    @(posedge clk);
                    i_wb_allowin <= (($urandom % 3) != 0);
                    @(negedge clk);
                    if (o_wb_valid && !i_wb_allowin && o_ex_ready) begin
                        err_cnt++;
                        $display("o_ex_ready is high while writeback stalls at %0t", $time);
                    end
                    if (o_wb_valid && i_wb_allowin) begin
                        check_pkt(q[got], ec[got], ev[got]);
                        got++;
                    end
                end
            end
        join
        @(posedge clk);
        i_wb_allowin <= 1'b1;
        @(negedge clk);
        expect_eq("o_wb_valid after the last item left", o_wb_valid, 0);
        report_test("back_pressure", e0);
    endtask

    task automatic timer_irq();
        int    e0;
        int    n;
        xlen_t v;
        e0 = err_cnt;
        v  = dword_random();
        run_item(mem_pkt(1'b1, OP_LD, CLINT_MTIMECMP_ADDR, v), 1'b0, '0, 0);
        run_item(mem_pkt(1'b0, OP_LD, CLINT_MTIMECMP_ADDR, dword_random()), 1'b1, v, 0);
        run_item(mem_pkt(1'b1, OP_LD, CLINT_MTIMECMP_ADDR, MTIP_CMP), 1'b0, '0, 0);
        run_item(mem_pkt(1'b1, OP_LD, CLINT_MTIME_ADDR, '0), 1'b0, '0, 0);
        // the mtime write lands on this edge
        @(posedge clk);
        n = 1;
        @(negedge clk);
        do begin
            @(negedge clk);
            n++;
        end while (!o_mtip && n < MTIP_CMP + 8);
        // mtime equals MTIP_CMP after MTIP_CMP edges and o_mtip follows one edge later
        expect_eq("negedges from mtime write to o_mtip", n, MTIP_CMP + 2);
        run_item(mem_pkt(1'b1, OP_LD, CLINT_MTIMECMP_ADDR, '1), 1'b0, '0, 0);
        @(posedge clk);
        repeat (2) @(negedge clk);
        expect_eq("o_mtip with mtimecmp all ones", o_mtip, 0);
        report_test("timer_irq", e0);
    endtask

    task automatic unmapped_window();
        int    e0;
        xlen_t a;
        e0 = err_cnt;
        run_item(mem_pkt(1'b0, OP_LD, CLINT_BASE + 64'h100, dword_random()), 1'b1, '0, 0);
        run_item(mem_pkt(1'b0, 3'b010, CLINT_BASE + 64'h8000, dword_random()), 1'b1, '0, 0);
        // same index bits as ram doubleword 8
        run_item(mem_pkt(1'b1, OP_LD, CLINT_BASE + 64'h40, dword_random()), 1'b0, '0, 0);
        a = RAM_BASE + 64'h40;
        run_item(mem_pkt(1'b0, OP_LD, a, dword_random()), 1'b1, predict_load(a, OP_LD),
                 RAM_LATENCY + 1);
        report_test("unmapped_window", e0);
    endtask

    task automatic reset_values();
        int e0;
        e0 = err_cnt;
        // arm the timer and park a stalled item so reset has something to clear
        run_item(mem_pkt(1'b1, OP_LD, CLINT_MTIMECMP_ADDR, '0), 1'b0, '0, 0);
        @(posedge clk);
        i_wb_allowin <= 1'b0;
        i_ex_valid   <= 1'b1;
        i_ex_pkt     <= random_pkt();
        @(posedge clk);
        i_ex_valid <= 1'b0;
        @(negedge clk);
        expect_eq("o_wb_valid before reset", o_wb_valid, 1);
        expect_eq("o_ex_ready before reset", o_ex_ready, 0);
        expect_eq("o_mtip before reset", o_mtip, 1);
        @(posedge clk);
        i_arst_n <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            expect_eq("o_wb_valid in reset", o_wb_valid, 0);
            expect_eq("o_ex_ready in reset", o_ex_ready, 1);
            expect_eq("o_mtip in reset", o_mtip, 0);
            expect_eq("o_ram_req in reset", i_mem_stage_top.i_lsu_stage.o_ram_req, 0);
            expect_eq("mtime in reset", i_mem_stage_top.i_clint.mtime_q, 0);
        end
        @(posedge clk);
        i_arst_n     <= 1'b1;
        i_wb_allowin <= 1'b1;
        run_item(mem_pkt(1'b0, OP_LD, CLINT_MTIMECMP_ADDR, dword_random()), 1'b1, '1, 0);
        report_test("reset_values", e0);
    endtask

    initial begin
        void'($urandom(SEED));
        err_cnt      = 0;
        checks       = 0;
        tests_run    = 0;
        i_arst_n     = 1'b0;
        i_ex_valid   = 1'b0;
        i_ex_pkt     = '0;
        i_wb_allowin = 1'b1;
        repeat (2) @(posedge clk);
        i_arst_n <= 1'b1;
        pass_through();
        store_then_load();
        back_pressure();
        timer_irq();
        unmapped_window();
        reset_values();
        $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* src/clint.sv */
`timescale 1ns/1ps

module clint (
    input  logic           clk,
    input  logic           i_arst_n,
    input  logic           i_we,
    input  logic           i_re,
    input  mem_pkg::xlen_t i_addr,
    input  mem_pkg::xlen_t i_wdata,
    output mem_pkg::xlen_t o_rdata,
    output logic           o_mtip
);
    import mem_pkg::*;

    xlen_t mtime_q;
    xlen_t mtimecmp_q;
    logic  sel_mtime;
    logic  sel_mtimecmp;
    logic  mtime_we;
    logic  mtimecmp_we;

    // register decode
    assign sel_mtime    = (i_addr == CLINT_MTIME_ADDR);
    assign sel_mtimecmp = (i_addr == CLINT_MTIMECMP_ADDR);
    assign mtime_we     = i_we && sel_mtime;
    assign mtimecmp_we  = i_we && sel_mtimecmp;

    // free running timer, a write overrides the increment
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mtime_q <= '0;
        end else if (mtime_we) begin
            mtime_q <= i_wdata;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    // compare value, all ones keeps the interrupt off
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mtimecmp_q <= '1;
        end else if (mtimecmp_we) begin
            mtimecmp_q <= i_wdata;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mtip <= 1'b0;
        end else begin
            o_mtip <= (mtime_q >= mtimecmp_q);
        end
    end

    // same cycle read, unmapped offsets read as zero
    always_comb begin
        o_rdata = '0;
        if (i_re) begin
            if (sel_mtime) begin
                o_rdata = mtime_q;
            end else if (sel_mtimecmp) begin
                o_rdata = mtimecmp_q;
            end
        end
    end

endmodule

/* src/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_req,
    input  mem_pkg::ram_req_s i_cmd,
    output logic              o_rvalid,
    output mem_pkg::xlen_t    o_rdata
);
    import mem_pkg::*;

    xlen_t             mem [RAM_WORDS];
    xlen_t             ram_off;
    logic [RAM_AW-1:0] idx;
    logic [5:0]        bit_off;
    logic [7:0]        size_mask;
    logic [7:0]        lane_mask;
    xlen_t             wdata_sh;
    xlen_t             rdata_sh;

    // valid and data pipelines give the fixed latency
    logic [RAM_LATENCY-1:0] vld_q;
    xlen_t                  dat_q [RAM_LATENCY];

    // doubleword index from the offset into the ram window
    assign ram_off = i_cmd.addr - RAM_BASE;
    assign idx     = ram_off[3 +: RAM_AW];
    assign bit_off = {i_cmd.addr[2:0], 3'b000};

    always_comb begin
        case (i_cmd.size)
            SZ_B:    size_mask = 8'h01;
            SZ_H:    size_mask = 8'h03;
            SZ_W:    size_mask = 8'h0F;
            default: size_mask = 8'hFF;
        endcase
    end

    // byte lanes touched by the store
    assign lane_mask = size_mask << i_cmd.addr[2:0];
    assign wdata_sh  = i_cmd.wdata << bit_off;

    // addressed bytes moved down to bit 0
    assign rdata_sh = mem[idx] >> bit_off;

    always_ff @(posedge clk) begin
        if (i_req && i_cmd.wr) begin
            for (int b = 0; b < 8; b++) begin
                if (lane_mask[b]) begin
                    mem[idx][b*8 +: 8] <= wdata_sh[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[RAM_LATENCY-2:0], i_req};
        end
    end

    always_ff @(posedge clk) begin
        if (i_req) begin
            dat_q[0] <= rdata_sh;
        end
        for (int s = 1; s < RAM_LATENCY; s++) begin
            dat_q[s] <= dat_q[s-1];
        end
    end

    // stores get a pulse too, it marks completion
    assign o_rvalid = vld_q[RAM_LATENCY-1];
    assign o_rdata  = dat_q[RAM_LATENCY-1];

endmodule

/* src/lsu_stage.sv */
`timescale 1ns/1ps

module lsu_stage (
    input  logic              clk,
    input  logic              i_arst_n,
    // execute side
    input  logic              i_ex_valid,
    input  mem_pkg::ex_pkt_s  i_ex_pkt,
    output logic              o_ex_ready,
    // writeback side
    output logic              o_wb_valid,
    output mem_pkg::wb_pkt_s  o_wb_pkt,
    input  logic              i_wb_allowin,
    // data ram
    output logic              o_ram_req,
    output mem_pkg::ram_req_s o_ram_cmd,
    input  logic              i_ram_rvalid,
    input  mem_pkg::xlen_t    i_ram_rdata,
    // clint
    output logic              o_clint_we,
    output logic              o_clint_re,
    output mem_pkg::xlen_t    o_clint_addr,
    output mem_pkg::xlen_t    o_clint_wdata,
    input  mem_pkg::xlen_t    i_clint_rdata
);
    import mem_pkg::*;

    logic       valid_q;
    ex_pkt_s    pkt_q;
    lsu_state_e state_q;
    lsu_state_e state_d;
    xlen_t      data_q;
    logic       data_en;
    xlen_t      addr;
    logic       is_mem;
    logic       in_clint;
    logic       is_clint;
    logic       is_ram;
    logic       ready_go;
    logic       leave;
    xlen_t      ram_ext;
    xlen_t      clint_val;

    // address decode
    assign addr     = pkt_q.alu_res;
    assign is_mem   = (pkt_q.mem_op != MEM_OP_NONE);
    assign in_clint = (addr >= CLINT_BASE) && (addr <= CLINT_LAST);
    assign is_clint = is_mem && in_clint;
    assign is_ram   = is_mem && !in_clint;

    // only ram accesses have to wait for data
    assign ready_go   = !is_ram || (state_q == S_DONE);
    assign o_wb_valid = valid_q && ready_go;
    assign leave      = o_wb_valid && i_wb_allowin;
    assign o_ex_ready = !valid_q || leave;

    // stage register
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else if (o_ex_ready) begin
            valid_q <= i_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ex_ready && i_ex_valid) begin
            pkt_q <= i_ex_pkt;
        end
    end

    always_comb begin
        state_d = state_q;
        data_en = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (valid_q && is_ram) begin
                    state_d = S_WAIT;
                end else if (valid_q && is_clint && !i_wb_allowin) begin
                    // freeze the clint value while the writeback side stalls
                    state_d = S_DONE;
                    data_en = 1'b1;
                end
            end
            S_WAIT: begin
                if (i_ram_rvalid) begin
                    state_d = S_DONE;
                    data_en = 1'b1;
                end
            end
            S_DONE: begin
                if (i_wb_allowin) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (data_en) begin
            data_q <= (state_q == S_WAIT) ? i_ram_rdata : i_clint_rdata;
        end
    end

    // one ram request per item, on its first cycle
    assign o_ram_req       = valid_q && is_ram && (state_q == S_IDLE);
    assign o_ram_cmd.addr  = addr;
    assign o_ram_cmd.wdata = pkt_q.rs2;
    assign o_ram_cmd.wr    = pkt_q.mem_wr;
    assign o_ram_cmd.size  = pkt_q.mem_op[1:0];

    // a clint store commits once, as the item leaves
    assign o_clint_we    = valid_q && is_clint && pkt_q.mem_wr && i_wb_allowin;
    assign o_clint_re    = valid_q && is_clint && !pkt_q.mem_wr && (state_q == S_IDLE);
    assign o_clint_addr  = addr;
    assign o_clint_wdata = pkt_q.rs2;

    // load extension, bit 2 of mem_op selects sign
    always_comb begin
        case (pkt_q.mem_op[1:0])
            SZ_B: ram_ext = pkt_q.mem_op[2] ? {{56{data_q[7]}}, data_q[7:0]}
                                            : {56'd0, data_q[7:0]};
            SZ_H: ram_ext = pkt_q.mem_op[2] ? {{48{data_q[15]}}, data_q[15:0]}
                                            : {48'd0, data_q[15:0]};
            SZ_W: ram_ext = pkt_q.mem_op[2] ? {{32{data_q[31]}}, data_q[31:0]}
                                            : {32'd0, data_q[31:0]};
            default: ram_ext = data_q;
        endcase
    end

    assign clint_val = (state_q == S_DONE) ? data_q : i_clint_rdata;

    // writeback packet
    always_comb begin
        o_wb_pkt.mem_out = is_clint ? clint_val : ram_ext;
        o_wb_pkt.alu_res = pkt_q.alu_res;
        o_wb_pkt.reg_src = pkt_q.reg_src;
        o_wb_pkt.reg_wr  = pkt_q.reg_wr;
        o_wb_pkt.intr_en = pkt_q.intr_en;
        o_wb_pkt.rs1     = pkt_q.rs1;
        o_wb_pkt.inst    = pkt_q.inst;
        o_wb_pkt.pc      = pkt_q.pc;
    end

endmodule

/* src/mem_pkg.sv */
package mem_pkg;

    // basic widths
    localparam int XLEN = 64;
    localparam int ILEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ILEN-1:0] inst_t;

    // bit 2 is signed, bits 1:0 are the access size
    typedef logic [2:0] mem_op_t;

    // writeback source: 0 alu, 1 mem, 2 csr
    typedef logic [1:0] reg_src_t;

    // size field of mem_op_t
    localparam logic [1:0] SZ_B = 2'd0;
    localparam logic [1:0] SZ_H = 2'd1;
    localparam logic [1:0] SZ_W = 2'd2;
    localparam logic [1:0] SZ_D = 2'd3;

    // unsigned doubleword encoding is reused as "no access"
    localparam mem_op_t MEM_OP_NONE = 3'b011;

    // clint window and its registers
    localparam xlen_t CLINT_BASE          = 64'h0000_0000_0200_0000;
    localparam xlen_t CLINT_LAST          = 64'h0000_0000_0200_BFFF;
    localparam xlen_t CLINT_MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
    localparam xlen_t CLINT_MTIME_ADDR    = 64'h0000_0000_0200_BFF8;

    // data ram
    localparam xlen_t RAM_BASE    = 64'h0000_0000_8000_0000;
    localparam int    RAM_WORDS   = 512;
    localparam int    RAM_AW      = $clog2(RAM_WORDS);
    localparam int    RAM_LATENCY = 2;

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_WAIT = 2'd1,
        S_DONE = 2'd2
    } lsu_state_e;

    // item handed over by execute
    typedef struct packed {
        logic     mem_wr;
        mem_op_t  mem_op;
        xlen_t    alu_res;
        xlen_t    rs2;
        xlen_t    rs1;
        reg_src_t reg_src;
        logic     reg_wr;
        logic     intr_en;
        inst_t    inst;
        xlen_t    pc;
    } ex_pkt_s;

    // item handed over to writeback
    typedef struct packed {
        xlen_t    mem_out;
        xlen_t    alu_res;
        reg_src_t reg_src;
        logic     reg_wr;
        logic     intr_en;
        xlen_t    rs1;
        inst_t    inst;
        xlen_t    pc;
    } wb_pkt_s;

    typedef struct packed {
        xlen_t      addr;
        xlen_t      wdata;
        logic       wr;
        logic [1:0] size;
    } ram_req_s;

endpackage

/* src/mem_stage_top.sv */
`timescale 1ns/1ps

module mem_stage_top (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_ex_valid,
    input  mem_pkg::ex_pkt_s i_ex_pkt,
    output logic             o_ex_ready,
    output logic             o_wb_valid,
    output mem_pkg::wb_pkt_s o_wb_pkt,
    input  logic             i_wb_allowin,
    output logic             o_mtip
);
    import mem_pkg::*;

    // stage to ram
    logic     ram_req;
    ram_req_s ram_cmd;
    logic     ram_rvalid;
    xlen_t    ram_rdata;

    // stage to clint
    logic  clint_we;
    logic  clint_re;
    xlen_t clint_addr;
    xlen_t clint_wdata;
    xlen_t clint_rdata;

    lsu_stage i_lsu_stage (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_ex_valid    (i_ex_valid),
        .i_ex_pkt      (i_ex_pkt),
        .o_ex_ready    (o_ex_ready),
        .o_wb_valid    (o_wb_valid),
        .o_wb_pkt      (o_wb_pkt),
        .i_wb_allowin  (i_wb_allowin),
        .o_ram_req     (ram_req),
        .o_ram_cmd     (ram_cmd),
        .i_ram_rvalid  (ram_rvalid),
        .i_ram_rdata   (ram_rdata),
        .o_clint_we    (clint_we),
        .o_clint_re    (clint_re),
        .o_clint_addr  (clint_addr),
        .o_clint_wdata (clint_wdata),
        .i_clint_rdata (clint_rdata)
    );

    clint i_clint (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_we     (clint_we),
        .i_re     (clint_re),
        .i_addr   (clint_addr),
        .i_wdata  (clint_wdata),
        .o_rdata  (clint_rdata),
        .o_mtip   (o_mtip)
    );

    data_ram i_data_ram (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_req    (ram_req),
        .i_cmd    (ram_cmd),
        .o_rvalid (ram_rvalid),
        .o_rdata  (ram_rdata)
    );

endmodule
